//--- logic/direction_decoder.sv
// direction decision for one packet entering a tree switch
module direction_decoder #(
	parameter int node_addr = 0,
	parameter int level = 0
) (
	input tree_pkg::packet_t pkt_i,
	output route_pkg::dir_t dir_o
);

	localparam int top_bit = tree_pkg::ADDR_W - 1;

	logic subtree_hit;
	logic branch_bit;

	if (level == 0) begin : g_root
		// every leaf lives below the root
		assign subtree_hit = 1'b1;
	end else begin : g_inner
		// upper address bits name the subtree of this node
		assign subtree_hit = pkt_i.dest[top_bit -: level] == level'(node_addr);
	end

	// first bit below the node prefix picks the child
	assign branch_bit = pkt_i.dest[top_bit - level];

	always_comb begin
		if (!pkt_i.valid)
			dir_o = route_pkg::DIR_VOID;
		else if (!subtree_hit)
			dir_o = route_pkg::DIR_UP;
		else if (branch_bit)
			dir_o = route_pkg::DIR_RIGHT;
		else
			dir_o = route_pkg::DIR_LEFT;
	end

endmodule

//--- logic/leaf_port.sv
// eject, inject and bounce logic between one element and its leaf link
module leaf_port #(
	parameter int leaf_addr = 0
) (
	input logic clk,
	input logic reset,
	input tree_pkg::packet_t link_i,
	output tree_pkg::packet_t link_o,
	input tree_pkg::packet_t inject_i,
	output tree_pkg::packet_t deliver_o,
	output logic resend_o
);

	logic for_me;

	assign for_me = link_i.valid && (link_i.dest == tree_pkg::leaf_addr_t'(leaf_addr));

	// a misrouted packet owns the uplink this cycle
	assign resend_o = link_i.valid && !for_me;

	always_ff @(posedge clk) begin
		if (reset) begin
			link_o <= '0;
			deliver_o <= '0;
		end else begin
			if (for_me)
				deliver_o <= link_i;
			else
				deliver_o <= '0;
			// bounce back into the tree, element holds its packet meanwhile
			if (resend_o)
				link_o <= link_i;
			else
				link_o <= inject_i;
		end
	end

endmodule

//--- logic/route_pkg.sv
// routing direction codes shared by decoders, arbiters and output muxes
package route_pkg;

	// as a request it says where a packet wants to go
	// as a mux select it names the input that feeds an output
	typedef enum logic [1:0] {
		DIR_VOID  = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP    = 2'b11
	} dir_t;

endpackage

//--- logic/tree_arbiter.sv
// output port assignment for a three-port deflection switch
module tree_arbiter #(
	parameter int level = 0
) (
	input route_pkg::dir_t dir_l_i,
	input route_pkg::dir_t dir_r_i,
	input route_pkg::dir_t dir_u_i,
	output route_pkg::dir_t sel_l_o,
	output route_pkg::dir_t sel_r_o,
	output route_pkg::dir_t sel_u_o
);

	if (level == 0) begin : g_root
		// root has only the two children, nothing ever asks for up
		always_comb begin
			sel_l_o = route_pkg::DIR_VOID;
			sel_r_o = route_pkg::DIR_VOID;
			sel_u_o = route_pkg::DIR_VOID;
			if (dir_l_i == route_pkg::DIR_LEFT)
				sel_l_o = route_pkg::DIR_LEFT;
			if (dir_r_i == route_pkg::DIR_RIGHT)
				sel_r_o = route_pkg::DIR_RIGHT;
			// crossing packet takes the other side or stays put
			if (dir_r_i == route_pkg::DIR_LEFT) begin
				if (sel_l_o == route_pkg::DIR_VOID)
					sel_l_o = route_pkg::DIR_RIGHT;
				else
					sel_r_o = route_pkg::DIR_RIGHT;
			end
			if (dir_l_i == route_pkg::DIR_RIGHT) begin
				if (sel_r_o == route_pkg::DIR_VOID)
					sel_r_o = route_pkg::DIR_LEFT;
				else
					sel_l_o = route_pkg::DIR_LEFT;
			end
		end
	end else begin : g_inner
		// an output is still free while its select is void
		always_comb begin
			sel_l_o = route_pkg::DIR_VOID;
			sel_r_o = route_pkg::DIR_VOID;
			sel_u_o = route_pkg::DIR_VOID;

			// turnbacks always win their own link
			if (dir_l_i == route_pkg::DIR_LEFT)
				sel_l_o = route_pkg::DIR_LEFT;
			if (dir_r_i == route_pkg::DIR_RIGHT)
				sel_r_o = route_pkg::DIR_RIGHT;
			if (dir_u_i == route_pkg::DIR_UP)
				sel_u_o = route_pkg::DIR_UP;

			// downlink from the parent, bounced back up when blocked
			if (dir_u_i == route_pkg::DIR_LEFT) begin
				if (sel_l_o == route_pkg::DIR_VOID)
					sel_l_o = route_pkg::DIR_UP;
				else
					sel_u_o = route_pkg::DIR_UP;
			end
			if (dir_u_i == route_pkg::DIR_RIGHT) begin
				if (sel_r_o == route_pkg::DIR_VOID)
					sel_r_o = route_pkg::DIR_UP;
				else
					sel_u_o = route_pkg::DIR_UP;
			end

			// side links, left child served first
			if (dir_l_i == route_pkg::DIR_RIGHT) begin
				if (sel_r_o == route_pkg::DIR_VOID)
					sel_r_o = route_pkg::DIR_LEFT;
				else if (sel_l_o == route_pkg::DIR_VOID)
					sel_l_o = route_pkg::DIR_LEFT;
				else
					sel_u_o = route_pkg::DIR_LEFT;
			end
			if (dir_r_i == route_pkg::DIR_LEFT) begin
				if (sel_l_o == route_pkg::DIR_VOID)
					sel_l_o = route_pkg::DIR_RIGHT;
				else if (sel_r_o == route_pkg::DIR_VOID)
					sel_r_o = route_pkg::DIR_RIGHT;
				else
					sel_u_o = route_pkg::DIR_RIGHT;
			end

			// uplinks last, deflected back toward where they came from
			if (dir_l_i == route_pkg::DIR_UP) begin
				if (sel_u_o == route_pkg::DIR_VOID)
					sel_u_o = route_pkg::DIR_LEFT;
				else if (sel_l_o == route_pkg::DIR_VOID)
					sel_l_o = route_pkg::DIR_LEFT;
				else
					sel_r_o = route_pkg::DIR_LEFT;
			end
			if (dir_r_i == route_pkg::DIR_UP) begin
				if (sel_u_o == route_pkg::DIR_VOID)
					sel_u_o = route_pkg::DIR_RIGHT;
				else if (sel_r_o == route_pkg::DIR_VOID)
					sel_r_o = route_pkg::DIR_RIGHT;
				else
					sel_l_o = route_pkg::DIR_RIGHT;
			end
		end
	end

endmodule

//--- logic/tree_network.sv
// top level binary tree of deflection switches with one leaf port per element
module tree_network (
	input logic clk,
	input logic reset,
	input tree_pkg::packet_t inject_i [tree_pkg::NUM_LEAVES],
	output tree_pkg::packet_t deliver_o [tree_pkg::NUM_LEAVES],
	output logic [tree_pkg::NUM_LEAVES-1:0] resend_o
);

	// heap numbering, node n has children 2n+1 and 2n+2
	// switches take 0 .. NUM_LEAVES-2, leaf ports follow
	localparam int num_nodes = 2 * tree_pkg::NUM_LEAVES - 1;

	// links indexed by their lower end
	// down_w runs parent to child, up_w child to parent
	tree_pkg::packet_t down_w [num_nodes];
	tree_pkg::packet_t up_w [num_nodes];

	// root has no parent
	assign down_w[0] = '0;

	for (genvar k = 0; k < tree_pkg::NUM_LEVELS; k++) begin : g_level
		for (genvar j = 0; j < (1 << k); j++) begin : g_node
			localparam int n = (1 << k) - 1 + j;

			tree_switch #(
				.node_addr(j),
				.level(k)
			) u_switch (
				.clk(clk),
				.reset(reset),
				.l_i(up_w[2*n+1]),
				.r_i(up_w[2*n+2]),
				.u_i(down_w[n]),
				.l_o(down_w[2*n+1]),
				.r_o(down_w[2*n+2]),
				.u_o(up_w[n])
			);
		end
	end

	// leaf m hangs below switch node (NUM_LEAVES-2+m)/2
	for (genvar m = 0; m < tree_pkg::NUM_LEAVES; m++) begin : g_leaf
		localparam int n = tree_pkg::NUM_LEAVES - 1 + m;

		leaf_port #(
			.leaf_addr(m)
		) u_leaf (
			.clk(clk),
			.reset(reset),
			.link_i(down_w[n]),
			.link_o(up_w[n]),
			.inject_i(inject_i[m]),
			.deliver_o(deliver_o[m]),
			.resend_o(resend_o[m])
		);
	end

endmodule

//--- logic/tree_pkg.sv
// network sizes, leaf address type and packet format
package tree_pkg;

	// eight processing elements, one per leaf
	localparam int NUM_LEAVES = 8;

	// leaf address width
	localparam int ADDR_W = $clog2(NUM_LEAVES);

	// one switch level per address bit
	localparam int NUM_LEVELS = ADDR_W;

	localparam int PAYLOAD_W = 8;

	typedef logic [ADDR_W-1:0] leaf_addr_t;

	// all zeros means no packet on the link
	typedef struct packed {
		logic valid;
		leaf_addr_t dest;
		logic [PAYLOAD_W-1:0] payload;
	} packet_t;

endpackage

//--- logic/tree_switch.sv
// registered three-port tree switch with decoders, arbiter and output muxes
module tree_switch #(
	parameter int node_addr = 0,
	parameter int level = 0
) (
	input logic clk,
	input logic reset,
	input tree_pkg::packet_t l_i,
	input tree_pkg::packet_t r_i,
	input tree_pkg::packet_t u_i,
	output tree_pkg::packet_t l_o,
	output tree_pkg::packet_t r_o,
	output tree_pkg::packet_t u_o
);

	route_pkg::dir_t dir_l;
	route_pkg::dir_t dir_r;
	route_pkg::dir_t dir_u;
	route_pkg::dir_t sel_l;
	route_pkg::dir_t sel_r;
	route_pkg::dir_t sel_u;

	// output mux, an unselected output carries no packet
	function automatic tree_pkg::packet_t pick(
		input route_pkg::dir_t sel,
		input tree_pkg::packet_t from_l,
		input tree_pkg::packet_t from_r,
		input tree_pkg::packet_t from_u
	);
		case (sel)
			route_pkg::DIR_LEFT: return from_l;
			route_pkg::DIR_RIGHT: return from_r;
			route_pkg::DIR_UP: return from_u;
			default: return '0;
		endcase
	endfunction

	direction_decoder #(.node_addr(node_addr), .level(level)) u_dec_l (
		.pkt_i(l_i),
		.dir_o(dir_l)
	);

	direction_decoder #(.node_addr(node_addr), .level(level)) u_dec_r (
		.pkt_i(r_i),
		.dir_o(dir_r)
	);

	direction_decoder #(.node_addr(node_addr), .level(level)) u_dec_u (
		.pkt_i(u_i),
		.dir_o(dir_u)
	);

	tree_arbiter #(.level(level)) u_arb (
		.dir_l_i(dir_l),
		.dir_r_i(dir_r),
		.dir_u_i(dir_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	// one cycle through the switch
	always_ff @(posedge clk) begin
		if (reset) begin
			l_o <= '0;
			r_o <= '0;
			u_o <= '0;
		end else begin
			l_o <= pick(sel_l, l_i, r_i, u_i);
			r_o <= pick(sel_r, l_i, r_i, u_i);
			u_o <= pick(sel_u, l_i, r_i, u_i);
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the tree network testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tree_network_tb \
	--Mdir obj_dir -o tree_network_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/tree_network_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- test/traffic_cases.txt
// columns: kind, test id, a, b, c (hex); kind 0 starts a test with mode a, random count b
// kind 1 is a packet from leaf a to leaf b with payload c; kind f ends the list
0 01 0 00 00
1 01 0 7 00
1 01 7 0 e1
1 01 1 4 22
1 01 4 1 83
1 01 2 3 44
1 01 5 6 a5
1 01 3 5 66
1 01 6 2 c7
0 02 0 00 00
1 02 0 0 08
1 02 1 1 28
1 02 2 2 48
1 02 3 3 68
1 02 4 4 88
1 02 5 5 a8
1 02 6 6 c8
1 02 7 7 e8
0 03 1 00 00
1 03 0 7 09
1 03 1 6 29
1 03 2 5 49
1 03 3 4 69
1 03 4 3 89
1 03 5 2 a9
1 03 6 1 c9
1 03 7 0 e9
0 04 1 00 00
1 04 0 3 0a
1 04 1 4 2a
1 04 2 5 4a
1 04 3 6 6a
1 04 4 7 8a
1 04 5 0 aa
1 04 6 1 ca
1 04 7 2 ea
0 05 2 c8 00
f 00 0 00 00

//--- test/tree_network_tb.sv
// testbench for tree_network with case reader, leaf drivers, scoreboard, checks and watchdog
module tree_network_tb;

	localparam int leaves = tree_pkg::NUM_LEAVES;
	localparam int buf_depth = 256;
	localparam int case_words = 512;
	// kind, test id and three fields per record
	localparam int rec_len = 5;

	logic clk;
	logic reset;
	tree_pkg::packet_t inject_i [tree_pkg::NUM_LEAVES] = '{default: '0};
	tree_pkg::packet_t deliver_o [tree_pkg::NUM_LEAVES];
	logic [tree_pkg::NUM_LEAVES-1:0] resend_o;

	// per leaf send queues, filled by the case reader
	tree_pkg::packet_t send_buf [leaves][buf_depth];
	logic gap_buf [leaves][buf_depth];
	int wr_ptr [leaves];
	int rd_ptr [leaves];
	int gap_at [leaves];

	// expected payload counts per destination
	int pend_cnt [leaves][256];
	int accepted;
	int delivered;
	int resend_cycles;
	int cycle_cnt = 0;
	int cycle_limit;
	logic [31:0] lfsr_state;
	logic [7:0] case_mem [case_words];

	tree_network uut (
		.clk(clk),
		.reset(reset),
		.inject_i(inject_i),
		.deliver_o(deliver_o),
		.resend_o(resend_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("error: %s is %0h, expected %0h", name, got, exp));
	endtask

	// no deliveries and no bounces for the given number of cycles
	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("resend_o", 32'(resend_o), 32'h0);
			for (int m = 0; m < leaves; m++)
				check_value($sformatf("deliver_o[%0d]", m), 32'(deliver_o[m]), 32'h0);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[31]};
		end
	endtask

	task automatic queue_packet(input int src, input int dest, input int payload, input logic gap);
		tree_pkg::packet_t pkt;
		pkt.valid = 1'b1;
		pkt.dest = dest[tree_pkg::ADDR_W-1:0];
		pkt.payload = payload[tree_pkg::PAYLOAD_W-1:0];
		if (src < 0 || src >= leaves || dest < 0 || dest >= leaves)
			report_failure($sformatf("packet from leaf %0d to leaf %0d is outside the network",
				src, dest));
		else if (wr_ptr[src] >= buf_depth)
			report_failure($sformatf("send queue of leaf %0d overflowed", src));
		else begin
			send_buf[src][wr_ptr[src]] = pkt;
			gap_buf[src][wr_ptr[src]] = gap;
			wr_ptr[src]++;
		end
	endtask

	// all queues empty and every accepted packet delivered
	task automatic wait_drained();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(posedge clk);
			busy = accepted != delivered;
			for (int m = 0; m < leaves; m++)
				if (rd_ptr[m] != wr_ptr[m])
					busy = 1'b1;
		end
	endtask

	// inputs change a little after each rising edge, the head is held while resend is high
	always @(posedge clk) begin
		#1;
		for (int m = 0; m < leaves; m++) begin
			if (reset) begin
				gap_at[m] = -1;
				inject_i[m] = '0;
			end else if (rd_ptr[m] == wr_ptr[m])
				inject_i[m] = '0;
			else if (gap_buf[m][rd_ptr[m]] && gap_at[m] != rd_ptr[m]) begin
				// one idle cycle before this packet
				gap_at[m] = rd_ptr[m];
				inject_i[m] = '0;
			end else
				inject_i[m] = send_buf[m][rd_ptr[m]];
		end
	end

	// mid cycle sampling of deliveries and accepted injections
	always @(negedge clk) begin
		for (int m = 0; m < leaves; m++) begin
			if (reset) begin
				rd_ptr[m] = 0;
				for (int p = 0; p < 256; p++)
					pend_cnt[m][p] = 0;
			end else begin
				if (deliver_o[m].valid) begin
					check_value($sformatf("deliver_o[%0d].dest", m), 32'(deliver_o[m].dest),
						32'(m));
					if (pend_cnt[m][deliver_o[m].payload] == 0)
						report_failure($sformatf("leaf %0d got payload %0h that nobody sent to it",
							m, deliver_o[m].payload));
					else begin
						pend_cnt[m][deliver_o[m].payload]--;
						delivered++;
					end
				end
				if (resend_o[m])
					resend_cycles++;
				// taken at the coming edge only when no bounce owns the uplink
				if (inject_i[m].valid && !resend_o[m]) begin
					pend_cnt[inject_i[m].dest][inject_i[m].payload]++;
					rd_ptr[m]++;
					accepted++;
				end
			end
		end
		if (reset) begin
			accepted = 0;
			delivered = 0;
			resend_cycles = 0;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
			report_failure($sformatf("timeout after %0d cycles, packets are still in flight",
				cycle_cnt));
	end

	initial begin
		int idx;
		int listed;
		int mode;
		int kind;
		int a;
		int b;
		int c;
		logic [31:0] dest_r;
		logic [31:0] pay_r;
		logic [31:0] gap_r;
		reset = 1'b1;
		lfsr_state = 32'h20cb4737;
		for (int m = 0; m < leaves; m++)
			wr_ptr[m] = 0;
		$readmemh("test/traffic_cases.txt", case_mem);

		// count listed packets for the cycle limit
		idx = 0;
		listed = 0;
		while (idx + rec_len <= case_words && case_mem[idx] != 8'hf) begin
			if (case_mem[idx] == 8'h1)
				listed++;
			else if (case_mem[idx] == 8'h0 && case_mem[idx+2] == 8'h2)
				listed += int'(case_mem[idx+3]);
			idx += rec_len;
		end
		cycle_limit = 200 * listed + 500;
		if (idx + rec_len > case_words)
			report_failure("the case file has no end record");

		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// idle network stays quiet
		expect_idle(10);

		idx = 0;
		mode = 0;
		while (case_mem[idx] != 8'hf) begin
			kind = int'(case_mem[idx]);
			a = int'(case_mem[idx+2]);
			b = int'(case_mem[idx+3]);
			c = int'(case_mem[idx+4]);
			if (kind == 0) begin
				wait_drained();
				mode = a;
				$display("test %0d, mode %0d", int'(case_mem[idx+1]), mode);
				if (mode == 2) begin
					for (int i = 0; i < b; i++) begin
						draw_bits(3, dest_r);
						draw_bits(8, pay_r);
						draw_bits(1, gap_r);
						queue_packet(i % leaves, int'(dest_r), int'(pay_r), gap_r[0]);
					end
					wait_drained();
				end
			end else if (kind == 1) begin
				queue_packet(a, b, c, 1'b0);
				// single packets travel alone
				if (mode == 0)
					wait_drained();
			end else
				report_failure($sformatf("case record %0d has an unknown kind %0h",
					idx / rec_len, kind));
			idx += rec_len;
		end
		wait_drained();

		// nothing may still circulate once every packet is home
		expect_idle(20);
		// the bursts force bounces at the leaves
		check_value("resend_o high in some cycle", 32'(resend_cycles != 0), 32'h1);
		$display("%0d packets delivered, %0d resend cycles", delivered, resend_cycles);
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- verilog.f
logic/tree_pkg.sv
logic/route_pkg.sv
logic/direction_decoder.sv
logic/tree_arbiter.sv
logic/tree_switch.sv
logic/leaf_port.sv
logic/tree_network.sv
test/tree_network_tb.sv
